// ==== gbe_cpu_pkg.sv ====
package gbe_cpu_pkg;

  // bus and field widths
  localparam int data_w     = 32;
  localparam int mac_w      = 48;
  localparam int arp_addr_w = 8;
  localparam int buf_addr_w = 9;
  localparam int size_w     = 12;
  localparam int occ_w      = 16;
  localparam int reg_idx_w  = 8;

  // address map, inclusive bounds
  localparam logic [data_w-1:0] regs_base  = 32'h0000_0000;
  localparam logic [data_w-1:0] regs_high  = 32'h0000_0FFF;
  localparam logic [data_w-1:0] arp_base   = 32'h0000_1000;
  localparam logic [data_w-1:0] arp_high   = 32'h0000_3FFF;
  localparam logic [data_w-1:0] txbuf_base = 32'h0000_4000;
  localparam logic [data_w-1:0] txbuf_high = 32'h0000_7FFF;
  localparam logic [data_w-1:0] rxbuf_base = 32'h0000_8000;
  localparam logic [data_w-1:0] rxbuf_high = 32'h0000_BFFF;

  // register word indices, address bits 9 to 2
  localparam logic [reg_idx_w-1:0] reg_core_type     = 8'd0;
  localparam logic [reg_idx_w-1:0] reg_buffer_size   = 8'd1;
  localparam logic [reg_idx_w-1:0] reg_word_length   = 8'd2;
  localparam logic [reg_idx_w-1:0] reg_mac_hi        = 8'd3;
  localparam logic [reg_idx_w-1:0] reg_mac_lo        = 8'd4;
  localparam logic [reg_idx_w-1:0] reg_ip            = 8'd5;
  localparam logic [reg_idx_w-1:0] reg_gateway       = 8'd6;
  localparam logic [reg_idx_w-1:0] reg_buffer_occ    = 8'd10;
  localparam logic [reg_idx_w-1:0] reg_enable        = 8'd11;
  localparam logic [reg_idx_w-1:0] reg_port          = 8'd12;
  localparam logic [reg_idx_w-1:0] reg_phy_status_hi = 8'd13;
  localparam logic [reg_idx_w-1:0] reg_phy_status_lo = 8'd14;
  localparam logic [reg_idx_w-1:0] reg_phy_ctrl_hi   = 8'd15;
  localparam logic [reg_idx_w-1:0] reg_phy_ctrl_lo   = 8'd16;
  localparam logic [reg_idx_w-1:0] reg_arp_size      = 8'd17;

  // identity bytes, 1 means gigabit core
  localparam logic [7:0] core_type     = 8'd1;
  localparam logic [7:0] core_revision = 8'd2;

  // buffer sizes in bytes
  localparam logic [occ_w-1:0] tx_buf_bytes = 16'd2048;
  localparam logic [occ_w-1:0] rx_buf_bytes = 16'd2048;

  // bytes per size count on each side of the core
  localparam logic [occ_w-1:0] tx_word_bytes = 16'd8;
  localparam logic [occ_w-1:0] rx_word_bytes = 16'd1;

  localparam logic [data_w-1:0] arp_entries = 32'd256;

endpackage

// ==== cpu_bus_if.sv ====
interface cpu_bus_if;
  import gbe_cpu_pkg::*;

  logic              req;
  logic              we;
  logic [3:0]        sel;
  logic [data_w-1:0] wdata;
  // address relative to the selected region base
  logic [data_w-1:0] offset;
  logic              reg_sel;
  logic              arp_sel;
  logic              txbuf_sel;
  logic              rxbuf_sel;
  // extra cycle of an arp or tx write
  logic              wr_wait;

  modport decode (
    output req, we, sel, wdata, offset, reg_sel, arp_sel, txbuf_sel, rxbuf_sel, wr_wait
  );

  modport regs (input req, we, sel, wdata, offset, reg_sel);

  modport mem (input req, we, sel, wdata, offset, arp_sel, txbuf_sel, rxbuf_sel, wr_wait);

endinterface

// ==== wb_slave_decode.sv ====
module wb_slave_decode (
  input  logic                           cpu_clk,
  input  logic                           cpu_rst,
  input  logic                           wb_stb_i,
  input  logic                           wb_cyc_i,
  input  logic                           wb_we_i,
  input  logic [gbe_cpu_pkg::data_w-1:0] wb_adr_i,
  input  logic [gbe_cpu_pkg::data_w-1:0] wb_dat_i,
  input  logic [3:0]                     wb_sel_i,
  input  logic [gbe_cpu_pkg::data_w-1:0] reg_rdata_i,
  input  logic [gbe_cpu_pkg::data_w-1:0] mem_rdata_i,
  input  logic                           mem_rd_i,
  cpu_bus_if.decode                      bus,
  output logic [gbe_cpu_pkg::data_w-1:0] wb_dat_o,
  output logic                           wb_ack_o
);
  import gbe_cpu_pkg::*;

  logic ack_q;
  logic wait_q;
  logic rmw_wr;

  // unsigned wrap turns a two-sided bound check into one compare
  function automatic logic in_region(
    input logic [data_w-1:0] addr,
    input logic [data_w-1:0] lo,
    input logic [data_w-1:0] hi
  );
    return (addr - lo) <= (hi - lo);
  endfunction

  assign bus.reg_sel   = in_region(wb_adr_i, regs_base, regs_high);
  assign bus.arp_sel   = in_region(wb_adr_i, arp_base, arp_high);
  assign bus.txbuf_sel = in_region(wb_adr_i, txbuf_base, txbuf_high);
  assign bus.rxbuf_sel = in_region(wb_adr_i, rxbuf_base, rxbuf_high);

  always_comb begin
    bus.offset = wb_adr_i - regs_base;
    if (bus.arp_sel) begin
      bus.offset = wb_adr_i - arp_base;
    end else if (bus.txbuf_sel) begin
      bus.offset = wb_adr_i - txbuf_base;
    end else if (bus.rxbuf_sel) begin
      bus.offset = wb_adr_i - rxbuf_base;
    end
  end

  // new transaction, one cycle only
  assign bus.req     = wb_stb_i && wb_cyc_i && !ack_q && !wait_q;
  assign bus.we      = wb_we_i;
  assign bus.sel     = wb_sel_i;
  assign bus.wdata   = wb_dat_i;
  assign bus.wr_wait = wait_q;

  // arp and tx writes need the old word before merging
  assign rmw_wr = wb_we_i && (bus.arp_sel || bus.txbuf_sel);

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      ack_q  <= 1'b0;
      wait_q <= 1'b0;
    end else if (wait_q) begin
      wait_q <= 1'b0;
      ack_q  <= 1'b1;
    end else begin
      ack_q  <= bus.req && !rmw_wr;
      wait_q <= bus.req && rmw_wr;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = mem_rd_i ? mem_rdata_i : reg_rdata_i;

endmodule

// ==== gbe_ctrl_regs.sv ====
module gbe_ctrl_regs #(
  parameter logic [gbe_cpu_pkg::mac_w-1:0]  local_mac       = '1,
  parameter logic [gbe_cpu_pkg::data_w-1:0] local_ip        = '1,
  parameter logic [15:0]                    local_port      = '1,
  parameter logic [7:0]                     local_gateway   = '0,
  parameter logic                           local_enable    = 1'b0,
  parameter logic                           cpu_promiscuous = 1'b0,
  parameter logic [gbe_cpu_pkg::data_w-1:0] phy_config      = '0,
  parameter logic                           cpu_tx_enable   = 1'b0,
  parameter logic                           cpu_rx_enable   = 1'b0
) (
  input  logic                           cpu_clk,
  input  logic                           cpu_rst,
  cpu_bus_if.regs                        bus,
  input  logic [gbe_cpu_pkg::size_w-1:0] rx_size_i,
  input  logic                           rx_ready_i,
  input  logic                           tx_done_i,
  output logic [gbe_cpu_pkg::data_w-1:0] reg_rdata_o,
  output logic                           rx_ack_o,
  output logic [gbe_cpu_pkg::size_w-1:0] tx_size_o,
  output logic                           tx_ready_o,
  output logic                           local_enable_o,
  output logic [gbe_cpu_pkg::mac_w-1:0]  local_mac_o,
  output logic [gbe_cpu_pkg::data_w-1:0] local_ip_o,
  output logic [15:0]                    local_port_o,
  output logic [7:0]                     local_gateway_o,
  output logic                           cpu_promiscuous_o,
  output logic [gbe_cpu_pkg::data_w-1:0] phy_control_o
);
  import gbe_cpu_pkg::*;

  logic [mac_w-1:0]     mac_q;
  logic [data_w-1:0]    ip_q;
  logic [15:0]          port_q;
  logic [7:0]           gateway_q;
  logic                 enable_q;
  logic                 promisc_q;
  logic [63:0]          phy_ctrl_q;
  logic [occ_w-1:0]     rx_size_q;
  logic [occ_w-1:0]     tx_size_q;
  logic                 tx_ready_q;
  logic                 rx_ack_q;
  logic [reg_idx_w-1:0] idx_q;
  logic [reg_idx_w-1:0] wr_idx;
  logic [data_w-1:0]    wr_word;
  logic                 reg_wr;

  function automatic logic [data_w-1:0] lane_merge(
    input logic [data_w-1:0] old_w,
    input logic [data_w-1:0] new_w,
    input logic [3:0]        lanes
  );
    logic [data_w-1:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (lanes[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // read value of each register index
  function automatic logic [data_w-1:0] reg_word(input logic [reg_idx_w-1:0] idx);
    case (idx)
      reg_core_type:
        return {7'b0, cpu_tx_enable, 7'b0, cpu_rx_enable, core_revision, core_type};
      reg_buffer_size:   return {tx_buf_bytes, rx_buf_bytes};
      reg_word_length:   return {tx_word_bytes, rx_word_bytes};
      reg_mac_hi:        return {16'h0, mac_q[47:32]};
      reg_mac_lo:        return mac_q[31:0];
      reg_ip:            return ip_q;
      reg_gateway:       return {24'h0, gateway_q};
      reg_buffer_occ:    return {tx_size_q, rx_size_q};
      reg_enable:        return {16'h0, 7'b0, promisc_q, 7'b0, enable_q};
      // port mask half not implemented
      reg_port:          return {16'h0, port_q};
      reg_phy_status_hi: return '0;
      // link always reported up
      reg_phy_status_lo: return 32'd1;
      reg_phy_ctrl_hi:   return phy_ctrl_q[63:32];
      reg_phy_ctrl_lo:   return phy_ctrl_q[31:0];
      reg_arp_size:      return arp_entries;
      default:           return '0;
    endcase
  endfunction

  assign wr_idx = bus.offset[reg_idx_w+1:2];
  assign reg_wr = bus.req && bus.reg_sel && bus.we;

  always_comb begin
    reg_rdata_o = reg_word(idx_q);
    wr_word     = lane_merge(reg_word(wr_idx), bus.wdata, bus.sel);
  end

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      mac_q      <= local_mac;
      ip_q       <= local_ip;
      port_q     <= local_port;
      gateway_q  <= local_gateway;
      enable_q   <= local_enable;
      promisc_q  <= cpu_promiscuous;
      phy_ctrl_q <= {32'h0, phy_config};
      rx_size_q  <= '0;
      tx_size_q  <= '0;
      tx_ready_q <= 1'b0;
      rx_ack_q   <= 1'b0;
      idx_q      <= '0;
    end else begin
      // core has sent the packet
      if (tx_done_i) begin
        tx_size_q  <= '0;
        tx_ready_q <= 1'b0;
      end
      // ack only when the cpu has freed its rx half
      rx_ack_q <= rx_ready_i && (rx_size_q == '0);
      if (rx_ready_i) begin
        rx_size_q <= {{(occ_w-size_w){1'b0}}, rx_size_i};
      end
      if (bus.req && bus.reg_sel) begin
        idx_q <= wr_idx;
      end
      // cpu writes take priority over core strobes
      if (reg_wr) begin
        case (wr_idx)
          reg_mac_hi:      mac_q[47:32] <= wr_word[15:0];
          reg_mac_lo:      mac_q[31:0]  <= wr_word;
          reg_ip:          ip_q         <= wr_word;
          reg_gateway:     gateway_q    <= wr_word[7:0];
          reg_port:        port_q       <= wr_word[15:0];
          reg_phy_ctrl_hi: phy_ctrl_q[63:32] <= wr_word;
          reg_phy_ctrl_lo: phy_ctrl_q[31:0]  <= wr_word;
          reg_enable: begin
            enable_q  <= wr_word[0];
            promisc_q <= wr_word[8];
          end
          reg_buffer_occ: begin
            if (|bus.sel[1:0]) begin
              rx_size_q <= wr_word[15:0];
            end
            if (|bus.sel[3:2]) begin
              tx_size_q <= wr_word[31:16];
            end
            // low size byte arms the transmit
            if (bus.sel[2]) begin
              tx_ready_q <= 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  assign local_mac_o       = mac_q;
  assign local_ip_o        = ip_q;
  assign local_port_o      = port_q;
  assign local_gateway_o   = gateway_q;
  assign local_enable_o    = enable_q;
  assign cpu_promiscuous_o = promisc_q;
  assign phy_control_o     = phy_ctrl_q[31:0];
  assign tx_size_o         = tx_size_q[size_w-1:0];
  assign tx_ready_o        = tx_ready_q;
  assign rx_ack_o          = rx_ack_q;

endmodule

// ==== gbe_mem_port.sv ====
module gbe_mem_port (
  input  logic                               cpu_clk,
  input  logic                               cpu_rst,
  cpu_bus_if.mem                             bus,
  input  logic [gbe_cpu_pkg::mac_w-1:0]      arp_rd_data_i,
  input  logic [gbe_cpu_pkg::data_w-1:0]     tx_buf_rd_data_i,
  input  logic [gbe_cpu_pkg::data_w-1:0]     rx_buf_rd_data_i,
  output logic [gbe_cpu_pkg::arp_addr_w-1:0] arp_addr_o,
  output logic [gbe_cpu_pkg::mac_w-1:0]      arp_wr_data_o,
  output logic                               arp_wr_en_o,
  output logic [gbe_cpu_pkg::buf_addr_w-1:0] tx_buf_addr_o,
  output logic [gbe_cpu_pkg::data_w-1:0]     tx_buf_wr_data_o,
  output logic                               tx_buf_wr_en_o,
  output logic [gbe_cpu_pkg::buf_addr_w-1:0] rx_buf_addr_o,
  output logic [gbe_cpu_pkg::data_w-1:0]     mem_rdata_o,
  output logic                               mem_rd_o
);
  import gbe_cpu_pkg::*;

  logic [mac_w-1:0] old_d;
  logic [mac_w-1:0] new_d;
  logic [mac_w-1:0] merged;
  logic [5:0]       lanes;
  logic [mac_w-1:0] wr_data_q;
  logic             arp_we_q;
  logic             tx_we_q;
  logic             mem_rd_q;

  // arp entries are two words apart, buffers one
  assign arp_addr_o    = bus.offset[10:3];
  assign tx_buf_addr_o = bus.offset[10:2];
  assign rx_buf_addr_o = bus.offset[10:2];

  always_comb begin
    if (bus.arp_sel) begin
      old_d = arp_rd_data_i;
      new_d = {bus.wdata[15:0], bus.wdata};
      // bit 2 clear selects the upper 16 bits via lanes 0 and 1
      lanes = bus.offset[2] ? {2'b00, bus.sel} : {bus.sel[1:0], 4'b0000};
    end else begin
      old_d = {16'h0, tx_buf_rd_data_i};
      new_d = {16'h0, bus.wdata};
      lanes = {2'b00, bus.sel};
    end
    for (int b = 0; b < 6; b++) begin
      merged[8*b +: 8] = lanes[b] ? new_d[8*b +: 8] : old_d[8*b +: 8];
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (bus.wr_wait) begin
      wr_data_q <= merged;
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      arp_we_q <= 1'b0;
      tx_we_q  <= 1'b0;
      mem_rd_q <= 1'b0;
    end else begin
      arp_we_q <= bus.wr_wait && bus.arp_sel;
      tx_we_q  <= bus.wr_wait && bus.txbuf_sel;
      mem_rd_q <= bus.req && !bus.we && (bus.arp_sel || bus.txbuf_sel || bus.rxbuf_sel);
    end
  end

  assign arp_wr_data_o    = wr_data_q;
  assign arp_wr_en_o      = arp_we_q;
  assign tx_buf_wr_data_o = wr_data_q[data_w-1:0];
  assign tx_buf_wr_en_o   = tx_we_q;
  assign mem_rd_o         = mem_rd_q;

  // address is held until ack so the region flags still pick the source
  always_comb begin
    if (bus.arp_sel) begin
      mem_rdata_o = bus.offset[2] ? arp_rd_data_i[31:0] : {16'h0, arp_rd_data_i[47:32]};
    end else if (bus.txbuf_sel) begin
      mem_rdata_o = tx_buf_rd_data_i;
    end else begin
      mem_rdata_o = rx_buf_rd_data_i;
    end
  end

endmodule

// ==== gbe_cpu_attach.sv ====
module gbe_cpu_attach #(
  parameter logic [gbe_cpu_pkg::mac_w-1:0]  local_mac       = '1,
  parameter logic [gbe_cpu_pkg::data_w-1:0] local_ip        = '1,
  parameter logic [15:0]                    local_port      = '1,
  parameter logic [7:0]                     local_gateway   = '0,
  parameter logic                           local_enable    = 1'b0,
  parameter logic                           cpu_promiscuous = 1'b0,
  parameter logic [gbe_cpu_pkg::data_w-1:0] phy_config      = '0,
  parameter logic                           cpu_tx_enable   = 1'b0,
  parameter logic                           cpu_rx_enable   = 1'b0
) (
  input  logic                               cpu_clk,
  input  logic                               cpu_rst,
  // wishbone slave
  input  logic                               wb_stb_i,
  input  logic                               wb_cyc_i,
  input  logic                               wb_we_i,
  input  logic [gbe_cpu_pkg::data_w-1:0]     wb_adr_i,
  input  logic [gbe_cpu_pkg::data_w-1:0]     wb_dat_i,
  input  logic [3:0]                         wb_sel_i,
  output logic [gbe_cpu_pkg::data_w-1:0]     wb_dat_o,
  output logic                               wb_ack_o,
  // local configuration
  output logic                               local_enable_o,
  output logic [gbe_cpu_pkg::mac_w-1:0]      local_mac_o,
  output logic [gbe_cpu_pkg::data_w-1:0]     local_ip_o,
  output logic [15:0]                        local_port_o,
  output logic [7:0]                         local_gateway_o,
  output logic                               cpu_promiscuous_o,
  output logic [gbe_cpu_pkg::data_w-1:0]     phy_control_o,
  // arp cache ram
  output logic [gbe_cpu_pkg::arp_addr_w-1:0] arp_addr_o,
  input  logic [gbe_cpu_pkg::mac_w-1:0]      arp_rd_data_i,
  output logic [gbe_cpu_pkg::mac_w-1:0]      arp_wr_data_o,
  output logic                               arp_wr_en_o,
  // rx buffer
  output logic [gbe_cpu_pkg::buf_addr_w-1:0] rx_buf_addr_o,
  input  logic [gbe_cpu_pkg::data_w-1:0]     rx_buf_rd_data_i,
  input  logic [gbe_cpu_pkg::size_w-1:0]     rx_size_i,
  output logic                               rx_ack_o,
  input  logic                               rx_ready_i,
  // tx buffer
  output logic [gbe_cpu_pkg::buf_addr_w-1:0] tx_buf_addr_o,
  input  logic [gbe_cpu_pkg::data_w-1:0]     tx_buf_rd_data_i,
  output logic [gbe_cpu_pkg::data_w-1:0]     tx_buf_wr_data_o,
  output logic                               tx_buf_wr_en_o,
  output logic [gbe_cpu_pkg::size_w-1:0]     tx_size_o,
  output logic                               tx_ready_o,
  input  logic                               tx_done_i
);
  import gbe_cpu_pkg::*;

  logic [data_w-1:0] reg_rdata;
  logic [data_w-1:0] mem_rdata;
  logic              mem_rd;

  cpu_bus_if u_bus ();

  wb_slave_decode u_wb_slave_decode (
    .cpu_clk     (cpu_clk),
    .cpu_rst     (cpu_rst),
    .wb_stb_i    (wb_stb_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .reg_rdata_i (reg_rdata),
    .mem_rdata_i (mem_rdata),
    .mem_rd_i    (mem_rd),
    .bus         (u_bus.decode),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o)
  );

  gbe_ctrl_regs #(
    .local_mac       (local_mac),
    .local_ip        (local_ip),
    .local_port      (local_port),
    .local_gateway   (local_gateway),
    .local_enable    (local_enable),
    .cpu_promiscuous (cpu_promiscuous),
    .phy_config      (phy_config),
    .cpu_tx_enable   (cpu_tx_enable),
    .cpu_rx_enable   (cpu_rx_enable)
  ) u_gbe_ctrl_regs (
    .cpu_clk           (cpu_clk),
    .cpu_rst           (cpu_rst),
    .bus               (u_bus.regs),
    .rx_size_i         (rx_size_i),
    .rx_ready_i        (rx_ready_i),
    .tx_done_i         (tx_done_i),
    .reg_rdata_o       (reg_rdata),
    .rx_ack_o          (rx_ack_o),
    .tx_size_o         (tx_size_o),
    .tx_ready_o        (tx_ready_o),
    .local_enable_o    (local_enable_o),
    .local_mac_o       (local_mac_o),
    .local_ip_o        (local_ip_o),
    .local_port_o      (local_port_o),
    .local_gateway_o   (local_gateway_o),
    .cpu_promiscuous_o (cpu_promiscuous_o),
    .phy_control_o     (phy_control_o)
  );

  gbe_mem_port u_gbe_mem_port (
    .cpu_clk          (cpu_clk),
    .cpu_rst          (cpu_rst),
    .bus              (u_bus.mem),
    .arp_rd_data_i    (arp_rd_data_i),
    .tx_buf_rd_data_i (tx_buf_rd_data_i),
    .rx_buf_rd_data_i (rx_buf_rd_data_i),
    .arp_addr_o       (arp_addr_o),
    .arp_wr_data_o    (arp_wr_data_o),
    .arp_wr_en_o      (arp_wr_en_o),
    .tx_buf_addr_o    (tx_buf_addr_o),
    .tx_buf_wr_data_o (tx_buf_wr_data_o),
    .tx_buf_wr_en_o   (tx_buf_wr_en_o),
    .rx_buf_addr_o    (rx_buf_addr_o),
    .mem_rdata_o      (mem_rdata),
    .mem_rd_o         (mem_rd)
  );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
  output logic cpu_clk,
  output logic cpu_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    cpu_clk = 1'b0;
    forever begin
      #2 cpu_clk = ~cpu_clk;
    end
  end

  initial begin
    cpu_rst = 1'b1;
    repeat (3) @(posedge cpu_clk);
    cpu_rst <= 1'b0;
  end

endmodule

// ==== gbe_cpu_attach_properties.sv ====
module gbe_cpu_attach_properties (
  input logic        cpu_clk,
  input logic        cpu_rst,
  input logic        wb_stb_i,
  input logic        wb_cyc_i,
  input logic        wb_we_i,
  input logic [31:0] wb_adr_i,
  input logic        wb_ack_o,
  input logic        arp_wr_en_o,
  input logic        tx_buf_wr_en_o,
  input logic        rx_ack_o,
  input logic        tx_ready_o,
  input logic        tx_done_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic rmw_adr;

  // arp cache and tx buffer share one contiguous span
  assign rmw_adr = (wb_adr_i >= 32'h0000_1000) && (wb_adr_i <= 32'h0000_7FFF);

  ack_single: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    wb_ack_o |=> !wb_ack_o) else $error("ack held longer than one cycle");

  ack_plain: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    $rose(wb_stb_i) && wb_cyc_i && !(wb_we_i && rmw_adr) |=> wb_ack_o)
    else $error("ack not one cycle after request");

  ack_rmw: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    $rose(wb_stb_i) && wb_cyc_i && wb_we_i && rmw_adr
      |=> !wb_ack_o ##1 (wb_ack_o && (arp_wr_en_o || tx_buf_wr_en_o)))
    else $error("write wait state or write enable misplaced");

  wr_en_with_ack: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    (arp_wr_en_o || tx_buf_wr_en_o) |-> wb_ack_o)
    else $error("memory write enable outside the ack cycle");

  rx_ack_pulse: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    rx_ack_o |=> !rx_ack_o) else $error("rx_ack longer than one cycle");

  tx_done_clears: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    tx_done_i |=> !tx_ready_o) else $error("tx_ready not cleared by tx_done");

endmodule

bind gbe_cpu_attach gbe_cpu_attach_properties u_props (
  .cpu_clk        (cpu_clk),
  .cpu_rst        (cpu_rst),
  .wb_stb_i       (wb_stb_i),
  .wb_cyc_i       (wb_cyc_i),
  .wb_we_i        (wb_we_i),
  .wb_adr_i       (wb_adr_i),
  .wb_ack_o       (wb_ack_o),
  .arp_wr_en_o    (arp_wr_en_o),
  .tx_buf_wr_en_o (tx_buf_wr_en_o),
  .rx_ack_o       (rx_ack_o),
  .tx_ready_o     (tx_ready_o),
  .tx_done_i      (tx_done_i)
);

// ==== tb_gbe_cpu_attach.sv ====
module tb_gbe_cpu_attach;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [47:0] p_mac  = 48'h0212_3456_789A;
  localparam logic [31:0] p_ip   = 32'hC0A8_0164;
  localparam logic [15:0] p_port = 16'h1F90;
  localparam logic [7:0]  p_gw   = 8'h01;
  localparam logic [31:0] p_phy  = 32'h0000_00A5;
  localparam int          max_cycles = 2000;

  logic        cpu_clk;
  logic        cpu_rst;
  logic        wb_stb_i;
  logic        wb_cyc_i;
  logic        wb_we_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        local_enable_o;
  logic [47:0] local_mac_o;
  logic [31:0] local_ip_o;
  logic [15:0] local_port_o;
  logic [7:0]  local_gateway_o;
  logic        cpu_promiscuous_o;
  logic [31:0] phy_control_o;
  logic [7:0]  arp_addr_o;
  logic [47:0] arp_rd_data_i;
  logic [47:0] arp_wr_data_o;
  logic        arp_wr_en_o;
  logic [8:0]  rx_buf_addr_o;
  logic [31:0] rx_buf_rd_data_i;
  logic [11:0] rx_size_i;
  logic        rx_ack_o;
  logic        rx_ready_i;
  logic [8:0]  tx_buf_addr_o;
  logic [31:0] tx_buf_rd_data_i;
  logic [31:0] tx_buf_wr_data_o;
  logic        tx_buf_wr_en_o;
  logic [11:0] tx_size_o;
  logic        tx_ready_o;
  logic        tx_done_i;

  // ram models and the expected contents
  logic [47:0] arp_mem [256];
  logic [31:0] tx_mem [512];
  logic [31:0] rx_mem [512];
  logic [47:0] arp_exp [256];
  logic [31:0] tx_exp [512];

  integer      seed = 66;
  int          cycles = 0;
  logic [31:0] rd;
  logic [47:0] mac_exp;
  logic [15:0] rx_exp;

  tb_clock_gen u_clk (.cpu_clk(cpu_clk), .cpu_rst(cpu_rst));

  gbe_cpu_attach #(
    .local_mac       (p_mac),
    .local_ip        (p_ip),
    .local_port      (p_port),
    .local_gateway   (p_gw),
    .local_enable    (1'b1),
    .cpu_promiscuous (1'b0),
    .phy_config      (p_phy),
    .cpu_tx_enable   (1'b1),
    .cpu_rx_enable   (1'b1)
  ) u_gbe_cpu_attach (.*);

  // fill words mix every address bit
  function automatic logic [47:0] arp_fill(input int i);
    return {16'(i * 257) ^ 16'hA5A5, 32'(i) * 32'h0101_0101 ^ 32'h5A5A_0000};
  endfunction

  function automatic logic [31:0] buf_fill(input int i, input logic [31:0] key);
    return (32'(i) * 32'h0001_0003) ^ key;
  endfunction

  initial begin
    arp_rd_data_i    = '0;
    tx_buf_rd_data_i = '0;
    rx_buf_rd_data_i = '0;
    for (int i = 0; i < 256; i++) begin
      arp_mem[i] = arp_fill(i);
      arp_exp[i] = arp_fill(i);
    end
    for (int i = 0; i < 512; i++) begin
      tx_mem[i] = buf_fill(i, 32'h7100_0000);
      tx_exp[i] = buf_fill(i, 32'h7100_0000);
      rx_mem[i] = buf_fill(i, 32'h8200_0000);
    end
  end

  // synchronous read, data one clock after the address
  always @(posedge cpu_clk) begin
    if (arp_wr_en_o) begin
      arp_mem[arp_addr_o] <= arp_wr_data_o;
    end
    if (tx_buf_wr_en_o) begin
      tx_mem[tx_buf_addr_o] <= tx_buf_wr_data_o;
    end
    arp_rd_data_i    <= arp_mem[arp_addr_o];
    tx_buf_rd_data_i <= tx_mem[tx_buf_addr_o];
    rx_buf_rd_data_i <= rx_mem[rx_buf_addr_o];
  end

  always @(posedge cpu_clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles without finishing the tests", cycles);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // one wishbone transfer, strobe held until ack
  task automatic wb_xfer(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                         input logic [3:0] sel, output logic [31:0] rdata);
    logic done;
    done = 1'b0;
    @(negedge cpu_clk);
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    while (!done) begin
      @(negedge cpu_clk);
      if (wb_ack_o) begin
        rdata    = wb_dat_o;
        wb_stb_i = 1'b0;
        wb_cyc_i = 1'b0;
        done     = 1'b1;
      end
    end
  endtask

  task automatic reg_read(input int idx, input logic [31:0] exp, input string name);
    logic [31:0] d;
    wb_xfer(1'b0, 32'(idx * 4), 32'h0, 4'hF, d);
    check(name, 64'(exp), 64'(d));
  endtask

  task automatic reg_write(input int idx, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] d;
    wb_xfer(1'b1, 32'(idx * 4), dat, sel, d);
  endtask

  // one rx_ready cycle from the core, then the rx_ack that should follow
  task automatic rx_pulse(input logic ack_exp);
    @(negedge cpu_clk);
    rx_ready_i = 1'b1;
    rx_size_i  = 12'($random(seed)) | 12'h001;
    rx_exp     = {4'h0, rx_size_i};
    @(negedge cpu_clk);
    rx_ready_i = 1'b0;
    check("rx_ack_o", 64'(ack_exp), 64'(rx_ack_o));
    @(negedge cpu_clk);
    check("rx_ack_o", 64'h0, 64'(rx_ack_o));
  endtask

  initial begin
    wb_stb_i   = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    wb_sel_i   = '0;
    rx_size_i  = '0;
    rx_ready_i = 1'b0;
    tx_done_i  = 1'b0;
    mac_exp    = p_mac;
    rx_exp     = '0;
    @(negedge cpu_clk);
    while (cpu_rst) begin
      @(negedge cpu_clk);
    end

    // reset values and identity words
    check("local_mac_o", 64'(p_mac), 64'(local_mac_o));
    check("local_ip_o", 64'(p_ip), 64'(local_ip_o));
    check("local_port_o", 64'(p_port), 64'(local_port_o));
    check("local_gateway_o", 64'(p_gw), 64'(local_gateway_o));
    check("local_enable_o", 64'h1, 64'(local_enable_o));
    check("cpu_promiscuous_o", 64'h0, 64'(cpu_promiscuous_o));
    check("phy_control_o", 64'(p_phy), 64'(phy_control_o));
    check("wb_ack_o", 64'h0, 64'(wb_ack_o));
    check("tx_ready_o", 64'h0, 64'(tx_ready_o));
    check("rx_ack_o", 64'h0, 64'(rx_ack_o));
    reg_read(0, 32'h0101_0201, "core_type");
    reg_read(1, 32'h0800_0800, "buffer_size");
    reg_read(2, 32'h0008_0001, "word_length");
    reg_read(17, 32'd256, "arp_size");
    reg_read(14, 32'd1, "phy_status_lo");
    reg_read(13, 32'd0, "phy_status_hi");
    reg_read(10, 32'd0, "buffer_occ");

    // byte lane register writes
    reg_write(3, 32'hFFFF_FFAB, 4'b0001);
    mac_exp[39:32] = 8'hAB;
    reg_write(4, 32'hCD00_0000, 4'b1000);
    mac_exp[31:24] = 8'hCD;
    check("local_mac_o", 64'(mac_exp), 64'(local_mac_o));
    reg_read(3, {16'h0, mac_exp[47:32]}, "mac_hi");
    reg_read(4, mac_exp[31:0], "mac_lo");
    reg_write(5, 32'h0011_2200, 4'b0110);
    check("local_ip_o", 64'h0000_0000_C011_2264, 64'(local_ip_o));
    reg_read(5, 32'hC011_2264, "ip");
    reg_write(12, 32'h0000_3300, 4'b0010);
    check("local_port_o", 64'h3390, 64'(local_port_o));
    reg_read(12, 32'h0000_3390, "port");
    reg_write(6, 32'hFFFF_FF07, 4'b1111);
    check("local_gateway_o", 64'h07, 64'(local_gateway_o));
    reg_read(6, 32'h0000_0007, "gateway");
    reg_write(11, 32'h0000_0100, 4'b0011);
    check("local_enable_o", 64'h0, 64'(local_enable_o));
    check("cpu_promiscuous_o", 64'h1, 64'(cpu_promiscuous_o));
    reg_read(11, 32'h0000_0100, "enable");
    reg_write(16, 32'h005A_0000, 4'b0100);
    check("phy_control_o", 64'h005A_00A5, 64'(phy_control_o));
    reg_write(15, 32'h1234_5678, 4'b1111);
    reg_read(15, 32'h1234_5678, "phy_ctrl_hi");
    reg_read(16, 32'h005A_00A5, "phy_ctrl_lo");

    // arp entry 5 upper half through lane 0, entry 7 low word lanes 2 and 3
    wb_xfer(1'b1, 32'h0000_1028, 32'h1111_11EE, 4'b0001, rd);
    arp_exp[5][39:32] = 8'hEE;
    wb_xfer(1'b1, 32'h0000_103C, 32'hBEEF_0000, 4'b1100, rd);
    arp_exp[7][31:16] = 16'hBEEF;
    wb_xfer(1'b0, 32'h0000_1028, 32'h0, 4'hF, rd);
    check("wb_dat_o", {48'h0, arp_exp[5][47:32]}, 64'(rd));
    wb_xfer(1'b0, 32'h0000_102C, 32'h0, 4'hF, rd);
    check("wb_dat_o", 64'(arp_exp[5][31:0]), 64'(rd));
    wb_xfer(1'b0, 32'h0000_103C, 32'h0, 4'hF, rd);
    check("wb_dat_o", 64'(arp_exp[7][31:0]), 64'(rd));
    // ram writes have landed by now
    check("arp_mem[5]", 64'(arp_exp[5]), 64'(arp_mem[5]));
    check("arp_mem[7]", 64'(arp_exp[7]), 64'(arp_mem[7]));

    // tx buffer merge, then the send handshake
    wb_xfer(1'b1, 32'h0000_400C, 32'hAA00_BB00, 4'b1010, rd);
    tx_exp[3][31:24] = 8'hAA;
    tx_exp[3][15:8]  = 8'hBB;
    wb_xfer(1'b0, 32'h0000_400C, 32'h0, 4'hF, rd);
    check("wb_dat_o", 64'(tx_exp[3]), 64'(rd));
    check("tx_mem[3]", 64'(tx_exp[3]), 64'(tx_mem[3]));
    reg_write(10, 32'h012C_0000, 4'b1100);
    check("tx_ready_o", 64'h1, 64'(tx_ready_o));
    check("tx_size_o", 64'd300, 64'(tx_size_o));
    tx_done_i = 1'b1;
    @(negedge cpu_clk);
    tx_done_i = 1'b0;
    check("tx_ready_o", 64'h0, 64'(tx_ready_o));
    check("tx_size_o", 64'h0, 64'(tx_size_o));

    // rx buffer reads and the ready/ack exchange
    wb_xfer(1'b0, 32'h0000_8024, 32'h0, 4'hF, rd);
    check("wb_dat_o", 64'(buf_fill(9, 32'h8200_0000)), 64'(rd));
    wb_xfer(1'b0, 32'h0000_87FC, 32'h0, 4'hF, rd);
    check("wb_dat_o", 64'(buf_fill(511, 32'h8200_0000)), 64'(rd));
    rx_pulse(1'b1);
    reg_read(10, {16'h0, rx_exp}, "buffer_occ");
    // size still held, so no ack
    rx_pulse(1'b0);
    reg_read(10, {16'h0, rx_exp}, "buffer_occ");
    reg_write(10, 32'h0000_0000, 4'b0011);
    reg_read(10, 32'h0, "buffer_occ");
    rx_pulse(1'b1);
    reg_read(10, {16'h0, rx_exp}, "buffer_occ");

    repeat (2) @(negedge cpu_clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
gbe_cpu_pkg.sv
cpu_bus_if.sv
wb_slave_decode.sv
gbe_ctrl_regs.sv
gbe_mem_port.sv
gbe_cpu_attach.sv
tb_clock_gen.sv
gbe_cpu_attach_properties.sv
tb_gbe_cpu_attach.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_gbe_cpu_attach
RTL_TOP   ?= gbe_cpu_attach
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
